//--- build.f
img_pkg.sv
grad_pkg.sv
pixel_reader.sv
row_buffer.sv
gradient_engine.sv
gradient_writer.sv
image_gradient.sv
image_gradient_chk.sv
tb_image_gradient.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the image gradient testbench under verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_image_gradient -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TESTBENCH PASSED" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

//--- tb_image_gradient.sv
module tb_image_gradient;

    // one run is the frame plus the flush row
    localparam int frame_beats = img_pkg::img_pixels + img_pkg::flush_beats;
    // watchdog covers three runs at 8 units per clock
    localparam int watchdog_time = 3 * frame_beats * 8;

    logic clk = 1'b0;
    logic reset, img_rd, grad_wr, done;
    img_pkg::img_addr_t img_addr, grad_addr;
    img_pkg::pixel_t img_di;
    grad_pkg::grad_word_t grad_do;

    // image memory, answers a read one cycle later
    img_pkg::pixel_t image [img_pkg::img_pixels];
    logic rd_pend = 1'b0;
    img_pkg::img_addr_t pend_addr;
    // gradient memory and writes per address
    grad_pkg::grad_word_t grad_mem [img_pkg::img_pixels];
    int wr_hits [img_pkg::img_pixels];
    int read_count, write_count, assert_fails;
    int errors = 0;
    integer seed = 32'h9660_e506;

    image_gradient image_gradient_inst (.*);

    always #4 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            errors = errors + 1;
            $display("error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // raster address of a pixel
    function automatic img_pkg::img_addr_t pixel_addr(input int row, input int col);
        return img_pkg::img_addr_t'(row * img_pkg::img_width + col);
    endfunction

    // expected word, a neighbour outside the frame gives zero
    function automatic logic [19:0] model_word(input int row, input int col);
        int here, gx, gy;
        here = int'(image[pixel_addr(row, col)]);
        gx = 0;
        gy = 0;
        if (col < img_pkg::img_width - 1) gx = int'(image[pixel_addr(row, col + 1)]) - here;
        if (row < img_pkg::img_height - 1) gy = int'(image[pixel_addr(row + 1, col)]) - here;
        // gx high, gy low, 10 bits each
        return {gx[9:0], gy[9:0]};
    endfunction

    // ------------------------------
    // memory models
    // ------------------------------

    // one clock of both memories, on the falling edge
    task automatic tick();
        @(negedge clk);
        img_di = rd_pend ? image[pend_addr] : 8'h00;
        rd_pend = img_rd;
        pend_addr = img_addr;
        // fresh counts for every run
        if (reset) begin
            read_count = 0;
            write_count = 0;
            wr_hits = '{default: 0};
        end
        if (img_rd) begin
            check_value("read_order", 32'(read_count), 32'(img_addr));
            read_count = read_count + 1;
        end
        if (grad_wr) begin
            check_value("write_order", 32'(write_count), 32'(grad_addr));
            check_value("write_after_done", 32'h0, 32'(done));
            grad_mem[grad_addr] = grad_do;
            wr_hits[grad_addr] = wr_hits[grad_addr] + 1;
            write_count = write_count + 1;
        end
    endtask

    // reset for three cycles, run to done, then check every word
    task automatic run_frame();
        img_pkg::img_addr_t a;
        reset = 1'b1;
        repeat (3) tick();
        check_value("done_in_reset", 32'h0, 32'(done));
        reset = 1'b0;
        while (!done) tick();
        check_value("read_count", 32'(img_pkg::img_pixels), 32'(read_count));
        check_value("write_count", 32'(img_pkg::img_pixels), 32'(write_count));
        for (int row = 0; row < img_pkg::img_height; row++) begin
            for (int col = 0; col < img_pkg::img_width; col++) begin
                a = pixel_addr(row, col);
                check_value("gradient_word", 32'(model_word(row, col)), 32'(grad_mem[a]));
                check_value("write_once", 32'h1, 32'(wr_hits[a]));
            end
        end
        // forced rows, +255 is 0x0ff and -255 is 0x301 in 10 bits
        check_value("gx_plus_255", 32'h0ff, 32'(grad_mem[pixel_addr(20, 0)][19:10]));
        check_value("gx_minus_255", 32'h301, 32'(grad_mem[pixel_addr(20, 1)][19:10]));
        check_value("gy_minus_255", 32'h301, 32'(grad_mem[pixel_addr(10, 7)][9:0]));
        // corner pixel has neither neighbour
        check_value("last_word_zero", 32'h0, 32'(grad_mem[pixel_addr(255, 255)]));
    endtask

    // ------------------------------
    // test sequence
    // ------------------------------
    initial begin
        reset = 1'b1;
        img_di = 8'h00;
        // random frame, then rows forced to the extreme steps
        for (int i = 0; i < img_pkg::img_pixels; i++) begin
            image[pixel_addr(0, i)] = img_pkg::pixel_t'($random(seed));
        end
        for (int col = 0; col < img_pkg::img_width; col++) begin
            image[pixel_addr(10, col)] = 8'hff;
            image[pixel_addr(11, col)] = 8'h00;
            image[pixel_addr(20, col)] = col[0] ? 8'hff : 8'h00;
        end
        run_frame();
        // done stays up, nothing more is written
        repeat (64) begin
            tick();
            check_value("done_held", 32'h1, 32'(done));
        end
        // second reset over the same frame
        run_frame();
        assert_fails = image_gradient_inst.image_gradient_chk_inst.fail_count;
        $display("reads %0d, writes %0d, check errors %0d, assertion failures %0d",
                 read_count, write_count, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // stuck run guard
    initial begin
        #(watchdog_time);
        $display("watchdog expired after %0d time units, done never arrived", watchdog_time);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

//--- image_gradient_chk.sv
module image_gradient_chk (
    input logic               clk,
    input logic               reset,
    input logic               img_rd,
    input img_pkg::img_addr_t img_addr,
    input logic               grad_wr,
    input img_pkg::img_addr_t grad_addr,
    input logic               done
);

    // failed assertions so far
    int fail_count = 0;

    task automatic count_failure(input string what);
        fail_count = fail_count + 1;
        $error("%s", what);
    endtask

    // ------------------------------
    // memory port rules
    // ------------------------------

    // strobes low once reset has been seen
    quiet_in_reset: assert property (@(posedge clk) reset && $past(reset) |-> !img_rd && !grad_wr)
        else count_failure("memory strobe active during reset");

    // reads walk the frame one address at a time
    read_step: assert property (@(posedge clk) disable iff (reset)
        img_rd && $past(img_rd) |-> img_addr == $past(img_addr) + 16'd1)
        else count_failure("image address did not step by one");

    // writes land in raster order
    write_step: assert property (@(posedge clk) disable iff (reset)
        grad_wr && $past(grad_wr) |-> grad_addr == $past(grad_addr) + 16'd1)
        else count_failure("gradient address did not step by one");

    // done is sticky until reset
    done_sticky: assert property (@(posedge clk) disable iff (reset)
        $past(done) && !$past(reset) |-> done)
        else count_failure("done fell without reset");

endmodule

bind image_gradient image_gradient_chk image_gradient_chk_inst (
    .clk       (clk),
    .reset     (reset),
    .img_rd    (img_rd),
    .img_addr  (img_addr),
    .grad_wr   (grad_wr),
    .grad_addr (grad_addr),
    .done      (done)
);

//--- image_gradient.sv
module image_gradient (
    input  logic                    clk,
    input  logic                    reset,
    output logic                    img_rd,
    output img_pkg::img_addr_t      img_addr,
    input  img_pkg::pixel_t         img_di,
    output logic                    grad_wr,
    output img_pkg::img_addr_t      grad_addr,
    output grad_pkg::grad_word_t    grad_do,
    output logic                    done
);

    // reader to engine
    logic            pix_valid;
    img_pkg::pixel_t pix_data;
    logic            pix_pad;

    // engine to writer
    logic                 gv_valid;
    grad_pkg::grad_word_t gv_word;

    // ------------------------------
    // datapath
    // ------------------------------

    // image memory side
    pixel_reader pixel_reader_inst (
        .clk       (clk),
        .reset     (reset),
        .img_rd    (img_rd),
        .img_addr  (img_addr),
        .img_di    (img_di),
        .pix_valid (pix_valid),
        .pix_data  (pix_data),
        .pix_pad   (pix_pad)
    );

    gradient_engine gradient_engine_inst (
        .clk       (clk),
        .reset     (reset),
        .pix_valid (pix_valid),
        .pix_data  (pix_data),
        .pix_pad   (pix_pad),
        .gv_valid  (gv_valid),
        .gv_word   (gv_word)
    );

    // gradient memory side
    gradient_writer gradient_writer_inst (
        .clk       (clk),
        .reset     (reset),
        .gv_valid  (gv_valid),
        .gv_word   (gv_word),
        .grad_wr   (grad_wr),
        .grad_addr (grad_addr),
        .grad_do   (grad_do),
        .done      (done)
    );

endmodule

//--- gradient_writer.sv
module gradient_writer (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    gv_valid,
    input  grad_pkg::grad_word_t    gv_word,
    output logic                    grad_wr,
    output img_pkg::img_addr_t      grad_addr,
    output grad_pkg::grad_word_t    grad_do,
    output logic                    done
);

    // ------------------------------
    // write port
    // ------------------------------

    // words arrive in raster order, so the address is just a count
    always_ff @(posedge clk) begin
        if (reset) begin
            grad_wr   <= 1'b0;
            grad_addr <= '0;
            done      <= 1'b0;
        end else begin
            grad_wr <= gv_valid & ~done;
            // step past each address once it is written
            if (grad_wr) begin
                grad_addr <= grad_addr + 1'b1;
            end
            // last address written, hold until reset
            if (grad_wr &&
                grad_addr == img_pkg::img_addr_t'(img_pkg::img_pixels - 1)) begin
                done <= 1'b1;
            end
        end
    end

    // data lines up with the strobe
    always_ff @(posedge clk) begin
        if (gv_valid) begin
            grad_do <= gv_word;
        end
    end

endmodule

//--- gradient_engine.sv
module gradient_engine (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    pix_valid,
    input  img_pkg::pixel_t         pix_data,
    input  logic                    pix_pad,
    output logic                    gv_valid,
    output grad_pkg::grad_word_t    gv_word
);

    // ------------------------------
    // window
    // ------------------------------

    // right neighbour of the target, straight from the line buffer
    img_pkg::pixel_t rb_out;
    // target pixel, previous line buffer output
    img_pkg::pixel_t rb_prev;
    // lower neighbour, the incoming beat
    img_pkg::pixel_t low_pix;

    // warm-up over the first row of beats
    logic [$clog2(img_pkg::img_width)-1:0] prime_cnt;
    logic primed;

    // position of the target pixel
    logic [$clog2(img_pkg::img_width)-1:0]  col;
    logic [$clog2(img_pkg::img_height)-1:0] row;

    grad_pkg::grad_comp_t gx;
    grad_pkg::grad_comp_t gy;

    row_buffer row_buffer_inst (
        .clk     (clk),
        .reset   (reset),
        .wr_en   (pix_valid),
        .wr_data (pix_data),
        .rd_data (rb_out)
    );

    // pad data carries nothing
    assign low_pix = pix_pad ? '0 : pix_data;

    always_ff @(posedge clk) begin
        if (pix_valid) begin
            rb_prev <= rb_out;
        end
    end

    // ------------------------------
    // differences and edge rules
    // ------------------------------

    // zero-extend then subtract, exact in 10 bits
    always_comb begin
        gx = $signed({2'b00, rb_out}) - $signed({2'b00, rb_prev});
        gy = $signed({2'b00, low_pix}) - $signed({2'b00, rb_prev});
        // no right neighbour in the last column
        if (col == ($bits(col))'(img_pkg::img_width - 1)) begin
            gx = '0;
        end
        // no lower neighbour in the last row
        if (row == ($bits(row))'(img_pkg::img_height - 1)) begin
            gy = '0;
        end
    end

    // beat counting and target position
    always_ff @(posedge clk) begin
        if (reset) begin
            prime_cnt <= '0;
            primed    <= 1'b0;
            col       <= '0;
            row       <= '0;
            gv_valid  <= 1'b0;
        end else begin
            gv_valid <= pix_valid & primed;
            if (pix_valid && !primed) begin
                prime_cnt <= prime_cnt + 1'b1;
                if (prime_cnt == ($bits(prime_cnt))'(img_pkg::img_width - 1)) begin
                    primed <= 1'b1;
                end
            end
            // advance raster position per emitted word
            if (pix_valid && primed) begin
                col <= col + 1'b1;
                if (col == ($bits(col))'(img_pkg::img_width - 1)) begin
                    row <= row + 1'b1;
                end
            end
        end
    end

    // output word, payload only
    always_ff @(posedge clk) begin
        if (pix_valid && primed) begin
            gv_word.gx <= gx;
            gv_word.gy <= gy;
        end
    end

endmodule

//--- row_buffer.sv
module row_buffer (
    input  logic             clk,
    input  logic             reset,
    input  logic             wr_en,
    input  img_pkg::pixel_t  wr_data,
    output img_pkg::pixel_t  rd_data
);

    // one row of history
    img_pkg::pixel_t mem [img_pkg::img_width];

    // slot taking the current beat
    logic [$clog2(img_pkg::img_width)-1:0] ptr;
    // slot overwritten on the next beat, the oldest one left
    logic [$clog2(img_pkg::img_width)-1:0] nxt;

    assign nxt = ptr + 1'b1;

    // ------------------------------
    // circular store
    // ------------------------------

    // oldest entry still held, written 255 beats ago
    // which is the right neighbour of the pixel one row above the beat
    assign rd_data = mem[nxt];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[ptr] <= wr_data;
        end
    end

    // pointer walks once per beat and wraps at the row length
    always_ff @(posedge clk) begin
        if (reset) begin
            ptr <= '0;
        end else if (wr_en) begin
            ptr <= nxt;
        end
    end

endmodule

//--- pixel_reader.sv
module pixel_reader (
    input  logic                 clk,
    input  logic                 reset,
    output logic                 img_rd,
    output img_pkg::img_addr_t   img_addr,
    input  img_pkg::pixel_t      img_di,
    output logic                 pix_valid,
    output img_pkg::pixel_t      pix_data,
    output logic                 pix_pad
);

    // one run per reset
    logic started;
    // read sweep
    logic rd_active;
    img_pkg::img_addr_t rd_addr;
    // strobe delayed to line up with img_di
    logic rd_d;
    // pad beats after the frame
    logic flush_active;
    logic [$clog2(img_pkg::flush_beats)-1:0] flush_cnt;

    // ------------------------------
    // address sweep and flush
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            started      <= 1'b0;
            rd_active    <= 1'b0;
            rd_addr      <= '0;
            rd_d         <= 1'b0;
            flush_active <= 1'b0;
            flush_cnt    <= '0;
        end else begin
            // kick off the sweep right after reset
            if (!started) begin
                started   <= 1'b1;
                rd_active <= 1'b1;
            end
            if (rd_active) begin
                rd_addr <= rd_addr + 1'b1;
                if (rd_addr == img_pkg::img_addr_t'(img_pkg::img_pixels - 1)) begin
                    rd_active <= 1'b0;
                end
            end
            rd_d <= rd_active;
            // last pixel beat is the one with no read behind it
            if (rd_d && !rd_active) begin
                flush_active <= 1'b1;
                flush_cnt    <= '0;
            end else if (flush_active) begin
                flush_cnt <= flush_cnt + 1'b1;
                if (flush_cnt == ($bits(flush_cnt))'(img_pkg::flush_beats - 1)) begin
                    flush_active <= 1'b0;
                end
            end
        end
    end

    assign img_rd   = rd_active;
    assign img_addr = rd_addr;

    // memory answers one cycle after the strobe
    assign pix_valid = rd_d | flush_active;
    assign pix_data  = img_di;
    assign pix_pad   = flush_active;

endmodule

//--- grad_pkg.sv
package grad_pkg;

    // ------------------------------
    // gradient component
    // ------------------------------

    // width of one difference
    // 9-bit exact result, sign-extended by one bit
    localparam int comp_w = 10;

    // signed difference, range -255 .. +255
    typedef logic signed [comp_w-1:0] grad_comp_t;

    // ------------------------------
    // packed memory word
    // ------------------------------

    // gx in the upper half, gy in the lower half
    typedef struct packed {
        grad_comp_t gx;
        grad_comp_t gy;
    } grad_word_t;

endpackage

//--- img_pkg.sv
package img_pkg;

    // ------------------------------
    // frame geometry
    // ------------------------------

    // pixels per row
    localparam int img_width = 256;
    // rows per frame
    localparam int img_height = 256;
    // pixels per frame, also the address space
    localparam int img_pixels = img_width * img_height;
    // frame address width
    localparam int addr_w = 16;
    // pad beats after the last pixel, one row to flush the line buffer
    localparam int flush_beats = img_width;

    // ------------------------------
    // types
    // ------------------------------

    // unsigned greyscale sample
    typedef logic [7:0] pixel_t;
    // raster address, row * img_width + column
    typedef logic [addr_w-1:0] img_addr_t;

endpackage
